/* src/spets_kbd_pkg.sv */
// Matrix sizes, PS/2 scan-code constants and shared types
// for the Spetsialist keyboard adapter
package spets_kbd_pkg;

	localparam int num_cols = 12;
	localparam int num_rows = 6;

	localparam logic [7:0] ps2_break      = 8'hf0;
	localparam logic [7:0] ps2_ext        = 8'he0;
	localparam logic [7:0] ps2_fake_shift = 8'h12;	// Only dropped after E0

	localparam logic [3:0] shift_col = 4'd11;
	localparam logic [2:0] shift_row = 3'd4;

	typedef logic [num_cols-1:0] scan_word_t;	// One bit per column
	typedef logic [num_rows-1:0] row_word_t;	// Rows of one column

	typedef struct packed {
		logic       ext;	// Came after E0
		logic [7:0] code;
	} key_code_t;

	typedef struct packed {
		logic      pressed;	// 0 for a break
		key_code_t key;
	} key_event_t;

	typedef struct packed {
		logic       hit;	// Code has a matrix position
		logic [3:0] col;
		logic [2:0] row;
	} matrix_pos_t;

	// Service keys, all extended
	localparam key_code_t key_delete    = '{ext: 1'b1, code: 8'h71};
	localparam key_code_t key_page_up   = '{ext: 1'b1, code: 8'h7d};
	localparam key_code_t key_page_down = '{ext: 1'b1, code: 8'h7a};

endpackage

/* src/ps2_rx.sv */
// PS/2 line synchroniser and 11-bit frame receiver, odd parity
`timescale 1ns/10ps

module ps2_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] rx_byte,
	output logic       byte_valid
);

	logic [2:0] clk_sync;	// Two sync stages plus previous level
	logic [1:0] data_sync;
	logic [3:0] bit_cnt;
	logic [9:0] frame;	// Parity, data, start once ten bits are in
	logic       fall;
	logic       frame_ok;

	assign fall = clk_sync[2] & ~clk_sync[1];

	// Start low, odd parity over data and parity, stop high
	assign frame_ok = ~frame[0] & (^frame[9:1]) & data_sync[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			clk_sync   <= 3'b111;	// Idle high, no false edge
			data_sync  <= 2'b11;
			bit_cnt    <= 4'd0;
			byte_valid <= 1'b0;
		end else begin
			clk_sync   <= {clk_sync[1:0], ps2_clk};
			data_sync  <= {data_sync[0], ps2_data};
			byte_valid <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= 4'd0;	// Stop bit sampled
					byte_valid <= frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fall) begin
			if (bit_cnt == 4'd10)
				rx_byte <= frame[8:1];
			else
				frame <= {data_sync[1], frame[9:1]};	// LSB first
		end
	end

endmodule

/* src/scan_code_parser.sv */
// Scan-code parser: F0/E0 prefixes, fake shift, service keys
// and key events for the matrix
`timescale 1ns/10ps

module scan_code_parser (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [7:0]                rx_byte,
	input  logic                      byte_valid,
	output spets_kbd_pkg::key_event_t ev,
	output logic                      ev_valid,
	output logic                      res_k,
	output logic                      turbo_k
);

	import spets_kbd_pkg::*;

	logic      brk;	// F0 seen
	logic      ext;	// E0 seen
	key_code_t key;

	assign key = '{ext: ext, code: rx_byte};

	always_ff @(posedge clk) begin
		if (reset) begin
			brk      <= 1'b0;
			ext      <= 1'b0;
			ev_valid <= 1'b0;
			res_k    <= 1'b0;
			turbo_k  <= 1'b0;
		end else begin
			ev_valid <= 1'b0;
			if (byte_valid) begin
				if (rx_byte == ps2_break) begin
					brk <= 1'b1;
				end else if (rx_byte == ps2_ext) begin
					ext <= 1'b1;
				end else begin
					brk <= 1'b0;
					ext <= 1'b0;
					// E0 12 and E0 F0 12 come from the keyboard itself
					if (!(ext && rx_byte == ps2_fake_shift)) begin
						case (key)
							key_delete:    res_k <= ~brk;	// Held while pressed
							key_page_up:   turbo_k <= 1'b1;
							key_page_down: turbo_k <= 1'b0;
							default:       ev_valid <= 1'b1;
						endcase
					end
				end
			end
		end
	end

	// Qualified by ev_valid
	always_ff @(posedge clk) begin
		if (byte_valid)
			ev <= '{pressed: ~brk, key: key};
	end

endmodule

/* src/key_map.sv */
// Latin key map from extended scan code to matrix column and row
`timescale 1ns/10ps

module key_map (
	input  spets_kbd_pkg::key_code_t   key,
	output spets_kbd_pkg::matrix_pos_t pos
);

	import spets_kbd_pkg::*;

	function automatic matrix_pos_t at(input int col, input int row);
		at = '{hit: 1'b1, col: 4'(col), row: 3'(row)};
	endfunction

	always_comb begin
		pos = '0;
		case ({key.ext, key.code})
			9'h005: pos = at(11, 5);	// F1
			9'h006: pos = at(10, 5);
			9'h004: pos = at(9, 5);
			9'h00c: pos = at(8, 5);
			9'h003: pos = at(7, 5);
			9'h00b: pos = at(6, 5);
			9'h083: pos = at(5, 5);	// F7
			9'h00a: pos = at(4, 5);
			9'h001: pos = at(3, 5);	// F9
			9'h012, 9'h059: pos = at(11, 4);	// Both shifts
			9'h016, 9'h069: pos = at(10, 4);	// 1, keypad too
			9'h01e, 9'h072: pos = at(9, 4);
			9'h026, 9'h07a: pos = at(8, 4);
			9'h025, 9'h06b: pos = at(7, 4);
			9'h02e, 9'h073: pos = at(6, 4);
			9'h036, 9'h074: pos = at(5, 4);
			9'h03d, 9'h06c: pos = at(4, 4);
			9'h03e, 9'h075: pos = at(3, 4);
			9'h046, 9'h07d: pos = at(2, 4);
			9'h045, 9'h070: pos = at(1, 4);	// 0
			9'h015: pos = at(11, 1);	// Q
			9'h01d: pos = at(9, 2);
			9'h024: pos = at(7, 3);
			9'h02d: pos = at(6, 2);
			9'h02c: pos = at(6, 1);
			9'h035: pos = at(10, 2);
			9'h03c: pos = at(9, 3);
			9'h043: pos = at(7, 1);
			9'h044: pos = at(5, 2);
			9'h04d: pos = at(7, 2);	// P
			9'h01c: pos = at(8, 2);	// A
			9'h01b: pos = at(9, 1);
			9'h023: pos = at(3, 2);
			9'h02b: pos = at(11, 2);
			9'h034: pos = at(5, 3);
			9'h033: pos = at(1, 3);
			9'h03b: pos = at(11, 3);
			9'h042: pos = at(8, 3);
			9'h04b: pos = at(4, 2);	// L
			9'h01a: pos = at(2, 3);	// Z
			9'h022: pos = at(5, 1);
			9'h021: pos = at(10, 3);
			9'h02a: pos = at(2, 2);
			9'h032: pos = at(4, 1);
			9'h031: pos = at(6, 3);
			9'h03a: pos = at(8, 1);	// M
			9'h05a, 9'h15a: pos = at(0, 0);	// Enter, keypad too
			9'h029: pos = at(5, 0);	// Space
			9'h16c: pos = at(10, 0);	// Home
			9'h175: pos = at(9, 0);	// Up
			9'h172: pos = at(8, 0);
			9'h16b: pos = at(4, 0);
			9'h174: pos = at(2, 0);	// Right
			default: pos = '0;
		endcase
	end

endmodule

/* src/key_matrix.sv */
// Key matrix state, shift indicator and the two scan read-out methods
`timescale 1ns/10ps

module key_matrix (
	input  logic                      clk,
	input  logic                      reset,
	input  spets_kbd_pkg::key_event_t ev,
	input  logic                      ev_valid,
	input  spets_kbd_pkg::scan_word_t sp_kb_scan,
	input  logic                      metod,
	output spets_kbd_pkg::scan_word_t sp_kb_out,
	output logic                      key_ss
);

	import spets_kbd_pkg::*;

	row_word_t   mat [num_cols];	// Bit set while key is down
	matrix_pos_t pos;
	row_word_t   row_hits;
	scan_word_t  col_hits;

	key_map i_key_map (
		.key (ev.key),
		.pos (pos)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int c = 0; c < num_cols; c++)
				mat[c] <= '0;
		end else if (ev_valid && pos.hit) begin
			mat[pos.col][pos.row] <= ev.pressed;
		end
	end

	assign key_ss = mat[shift_col][shift_row];

	// Method 0 drives columns and reads rows, method 1 the other way round
	always_comb begin
		row_hits = '0;
		for (int c = 0; c < num_cols; c++) begin
			if (!sp_kb_scan[c])
				row_hits = row_hits | mat[c];
			col_hits[c] = |(mat[c] & ~sp_kb_scan[num_rows-1:0]);
		end
	end

	assign sp_kb_out = metod ? ~col_hits : {{(num_cols-num_rows){1'b1}}, ~row_hits};

endmodule

/* src/spets_keyboard.sv */
// PS/2 keyboard to Spetsialist key matrix, top level
`timescale 1ns/10ps

module spets_keyboard (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      ps2_clk,
	input  logic                      ps2_data,
	input  spets_kbd_pkg::scan_word_t sp_kb_scan,
	input  logic                      metod,
	output spets_kbd_pkg::scan_word_t sp_kb_out,
	output logic                      key_ss,
	output logic                      res_k,
	output logic                      turbo_k
);

	import spets_kbd_pkg::*;

	logic [7:0] rx_byte;
	logic       byte_valid;
	key_event_t ev;
	logic       ev_valid;

	ps2_rx i_ps2_rx (
		.clk        (clk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid)
	);

	scan_code_parser i_parser (
		.clk        (clk),
		.reset      (reset),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid),
		.ev         (ev),
		.ev_valid   (ev_valid),
		.res_k      (res_k),
		.turbo_k    (turbo_k)
	);

	key_matrix i_matrix (
		.clk        (clk),
		.reset      (reset),
		.ev         (ev),
		.ev_valid   (ev_valid),
		.sp_kb_scan (sp_kb_scan),
		.metod      (metod),
		.sp_kb_out  (sp_kb_out),
		.key_ss     (key_ss)
	);

endmodule

/* dv/tb_spets_keyboard.sv */
// Testbench for the Spetsialist keyboard adapter: PS/2 frame driver,
// compare tasks, directed tests and a cycle timeout
`timescale 1ns/10ps

module tb_spets_keyboard;

	import spets_kbd_pkg::*;

	localparam int ps2_half       = 8;	// System clocks per PS/2 half-period
	localparam int settle_cycles  = 10;
	localparam int timeout_cycles = 30000;	// About 40 frames of 200 cycles plus margin
	localparam int num_keys       = 10;

	// Keys for the method 1 test and their matrix positions, ext bit on top
	localparam logic [8:0] pick_codes [num_keys] = '{
		9'h016, 9'h015, 9'h05a, 9'h029, 9'h005, 9'h01a, 9'h04b, 9'h03a, 9'h175, 9'h04d
	};
	localparam int pick_cols [num_keys] = '{10, 11, 0, 5, 11, 2, 4, 8, 9, 7};
	localparam int pick_rows [num_keys] = '{4, 1, 0, 0, 5, 3, 2, 1, 0, 2};

	logic       clk;
	logic       reset;
	logic       ps2_clk;
	logic       ps2_data;
	scan_word_t sp_kb_scan;
	logic       metod;
	scan_word_t sp_kb_out;
	logic       key_ss;
	logic       res_k;
	logic       turbo_k;

	string test_name;
	int    cycle_count = 0;
	int    seed = 29;

	spets_keyboard i_dut (
		.clk        (clk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.sp_kb_scan (sp_kb_scan),
		.metod      (metod),
		.sp_kb_out  (sp_kb_out),
		.key_ss     (key_ss),
		.res_k      (res_k),
		.turbo_k    (turbo_k)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("=== FAIL ===");
			$fatal(1);
		end
	end

	task automatic check_out(input string what, input scan_word_t expected,
			input scan_word_t actual);
		if (actual !== expected) begin
			$display("ERROR %s (%s): expected %h, actual %h", test_name, what, expected, actual);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s (%s): expected %b, actual %b", test_name, what, expected, actual);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	// Start, 8 data bits LSB first, odd parity, stop
	task automatic send_byte(input logic [7:0] data, input logic flip_parity);
		logic [10:0] frame;
		frame = {1'b1, (~^data) ^ flip_parity, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(negedge clk);
			ps2_data = frame[i];
			repeat (ps2_half) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (ps2_half) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic press_key(input key_code_t key);
		if (key.ext)
			send_byte(ps2_ext, 1'b0);
		send_byte(key.code, 1'b0);
		repeat (settle_cycles) @(negedge clk);
	endtask

	task automatic release_key(input key_code_t key);
		if (key.ext)
			send_byte(ps2_ext, 1'b0);
		send_byte(ps2_break, 1'b0);
		send_byte(key.code, 1'b0);
		repeat (settle_cycles) @(negedge clk);
	endtask

	// Scan is applied on one falling edge and the output read on the next
	task automatic expect_out(input string what, input logic m, input scan_word_t scan,
			input scan_word_t expected);
		@(negedge clk);
		metod = m;
		sp_kb_scan = scan;
		@(negedge clk);
		check_out(what, expected, sp_kb_out);
	endtask

	task automatic after_reset();
		test_name = "after_reset";
		for (int m = 0; m < 2; m++) begin
			expect_out("scan all low", 1'(m), '0, '1);
			expect_out("scan all high", 1'(m), '1, '1);
		end
		check_flag("res_k", 1'b0, res_k);
		check_flag("turbo_k", 1'b0, turbo_k);
		check_flag("key_ss", 1'b0, key_ss);
	endtask

	task automatic make_break_method0();
		key_code_t one;
		test_name = "make_break_method0";
		one = '{ext: 1'b0, code: 8'h16};
		press_key(one);
		expect_out("column 10", 1'b0, ~scan_word_t'(1 << 10), 12'hfef);
		expect_out("column 3", 1'b0, ~scan_word_t'(1 << 3), '1);
		release_key(one);
		expect_out("column 10 released", 1'b0, ~scan_word_t'(1 << 10), '1);
	endtask

	task automatic method1_readout();
		key_code_t  a_key;
		key_code_t  other;
		int         col;
		int         row;
		int         idx;
		scan_word_t scan;
		scan_word_t expected;
		test_name = "method1_readout";
		a_key = '{ext: 1'b0, code: 8'h1c};	// Column 8, row 2
		idx = int'($unsigned($random(seed)) % num_keys);
		other = pick_codes[idx];
		col = pick_cols[idx];
		row = pick_rows[idx];
		press_key(a_key);
		press_key(other);
		for (int r = 0; r < num_rows; r++) begin
			scan = '1;
			scan[r] = 1'b0;
			expected = '1;
			if (r == 2)
				expected[8] = 1'b0;
			if (r == row)
				expected[col] = 1'b0;
			expect_out($sformatf("row %0d", r), 1'b1, scan, expected);
		end
		expected = '1;
		expected[8] = 1'b0;
		expected[col] = 1'b0;
		expect_out("all rows", 1'b1, 12'hfc0, expected);
		release_key(a_key);
		release_key(other);
		expect_out("all rows released", 1'b1, 12'hfc0, '1);
	endtask

	task automatic service_keys();
		key_code_t del;
		test_name = "service_keys";
		del = '{ext: 1'b1, code: 8'h71};
		press_key(del);
		check_flag("res_k set", 1'b1, res_k);
		expect_out("matrix after delete", 1'b0, '0, '1);
		release_key(del);
		check_flag("res_k cleared", 1'b0, res_k);
		press_key('{ext: 1'b1, code: 8'h7d});
		check_flag("turbo_k set", 1'b1, turbo_k);
		press_key('{ext: 1'b1, code: 8'h7a});
		check_flag("turbo_k cleared", 1'b0, turbo_k);
		press_key('{ext: 1'b1, code: 8'h12});	// Fake shift
		check_flag("key_ss after fake shift", 1'b0, key_ss);
		expect_out("matrix after fake shift", 1'b0, '0, '1);
	endtask

	task automatic shift_and_bad_frame();
		test_name = "shift_and_bad_frame";
		press_key('{ext: 1'b0, code: 8'h12});
		check_flag("key_ss", 1'b1, key_ss);
		expect_out("shift column 11", 1'b0, ~scan_word_t'(1 << 11), 12'hfef);
		send_byte(8'h1e, 1'b1);
		repeat (settle_cycles) @(negedge clk);
		expect_out("bad parity column 9", 1'b0, ~scan_word_t'(1 << 9), '1);
		press_key('{ext: 1'b0, code: 8'h1e});
		expect_out("valid column 9", 1'b0, ~scan_word_t'(1 << 9), 12'hfef);
	endtask

	initial begin
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		sp_kb_scan = '1;
		metod = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		after_reset();
		make_break_method0();
		method1_readout();
		service_keys();
		shift_and_bad_frame();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* flist.f */
src/spets_kbd_pkg.sv
src/ps2_rx.sv
src/scan_code_parser.sv
src/key_map.sv
src/key_matrix.sv
src/spets_keyboard.sv
dv/tb_spets_keyboard.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

top=tb_spets_keyboard

verilator --binary --timing --top-module "$top" -f flist.f -o "V$top"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/"V$top"
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished cleanly"
exit 0
